/* spi_slave_top.f */
common/spi_slave_pkg.sv
design/spi_sck_sync.sv
spi_char/spi_char_trx.sv
spi_char/spi_word_pack.sv
design/spi_slave_top.sv
verification/spi_slave_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the SPI slave testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f spi_slave_top.f --top-module spi_slave_tb -Mdir obj_dir \
    && ./obj_dir/Vspi_slave_tb > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat "$LOG"

grep -qx "TEST OK" "$LOG" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verification/spi_slave_tb.sv */
`timescale 1ns/1ns

module spi_slave_tb;
    import spi_slave_pkg::*;

    localparam int n_frames       = 200;
    localparam int reset_cycles   = 16;
    localparam int settle_cycles  = 4;
    localparam int setup_cycles   = 10;
    localparam int half_min       = 8;
    localparam int half_max       = 12;
    localparam int gap_min        = 10;
    localparam int gap_max        = 24;
    localparam int frame_bits_max = 32;
    localparam int frame_max_cycles = settle_cycles + setup_cycles + half_max
                                    + frame_bits_max * 2 * half_max + gap_max + 4;
    localparam int timeout_cycles = n_frames * frame_max_cycles * 2;

    logic                      S_REV;
    logic                      S_RESETN;
    logic                      enable;
    logic                      cpol;
    logic                      cpha;
    logic                      lsb_first;
    logic [char_len_nbits-1:0] char_len;
    logic [word_nbits-1:0]     tx_word;
    logic                      spi_cs;
    logic                      spi_sck;
    logic                      spi_mosi;
    logic                      spi_miso;
    logic [word_nbits-1:0]     rx_word;
    logic                      rx_valid;
    logic                      tx_load;

    int          cycle  = 0;
    int          errors = 0;
    int          frames = 0;
    int          words  = 0;
    int          rx_count = 0;
    int          tx_count = 0;
    int          last_sample = 0;
    logic        sck_started = 1'b0;
    logic [31:0] exp_word = '0;
    logic [31:0] rng = 32'd86446;

    spi_slave_top u_spi_slave_top (
        .S_REV     (S_REV),
        .S_RESETN  (S_RESETN),
        .enable    (enable),
        .cpol      (cpol),
        .cpha      (cpha),
        .lsb_first (lsb_first),
        .char_len  (char_len),
        .tx_word   (tx_word),
        .spi_cs    (spi_cs),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid),
        .tx_load   (tx_load)
    );

    initial begin
        S_REV = 1'b0;
        forever #50 S_REV = ~S_REV;
    end

    always @(posedge S_REV) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = rand_word();
        return int'(r % 32'(n));
    endfunction

    // n cycles from the last drive, stopping on the negedge before the next one
    task automatic wait_to_sample(input int n);
        repeat (n - 1) @(posedge S_REV);
        @(negedge S_REV);
    endtask

    // outputs are stable at the negedge
    always @(negedge S_REV) begin
        if (S_RESETN && rx_valid) begin
            rx_count++;
            words++;
            assert (rx_word == exp_word) else begin
                errors++;
                $display("Fail %0t: rx_word %h, expected %h", $time, rx_word, exp_word);
            end
            assert (cycle == last_sample + 5) else begin
                errors++;
                $display("Fail %0t: rx_valid at cycle %0d, expected cycle %0d",
                         $time, cycle, last_sample + 5);
            end
        end
        if (S_RESETN && tx_load) begin
            tx_count++;
            assert (!sck_started) else begin
                errors++;
                $display("Fail %0t: tx_load after the first SCK edge", $time);
            end
        end
    end

    task automatic run_frame(input logic [1:0] mode, input logic lsb, input logic [3:0] len,
                             input logic en, input logic cut_short);
        int          nb;
        int          nchars;
        int          slot_w;
        int          total;
        int          stop_at;
        int          half;
        int          gap;
        int          b;
        int          c;
        int          j;
        int          pos;
        int          exp_rx;
        logic [15:0] mask;
        logic [15:0] got;
        logic [15:0] mosi_ch [4];
        logic [15:0] exp_tx [4];
        logic [31:0] word;
        logic [31:0] wide;
        nb      = int'(len) + 1;
        nchars  = (int'(len) <= byte_mode_max_len) ? 4 : 2;
        slot_w  = (int'(len) <= byte_mode_max_len) ? 8 : 16;
        total   = nchars * nb;
        stop_at = cut_short ? 1 + rand_below(total - 1) : total;
        half    = half_min + rand_below(half_max - half_min + 1);
        gap     = gap_min + rand_below(gap_max - gap_min + 1);
        exp_rx  = (en && !cut_short) ? 1 : 0;
        mask    = 16'hffff >> (16 - nb);
        word    = rand_word();
        exp_word = '0;
        for (c = 0; c < nchars; c++) begin
            wide       = rand_word();
            mosi_ch[c] = wide[15:0] & mask;
            wide       = word >> (c * slot_w);
            exp_tx[c]  = en ? (wide[15:0] & mask) : mask;  // idle high when disabled
            wide       = {16'h0000, mosi_ch[c]};
            exp_word   = exp_word | (wide << (c * slot_w));
        end

        @(posedge S_REV);
        enable    <= en;
        cpol      <= mode[1];
        cpha      <= mode[0];
        lsb_first <= lsb;
        char_len  <= len;
        tx_word   <= word;
        spi_sck   <= mode[1];
        rx_count    = 0;
        tx_count    = 0;
        sck_started = 1'b0;
        repeat (settle_cycles) @(posedge S_REV);
        spi_cs <= 1'b0;
        got = '0;

        for (b = 0; b < stop_at; b++) begin
            c   = b / nb;
            j   = b % nb;
            pos = lsb ? j : nb - 1 - j;
            if (!mode[0]) begin
                spi_mosi <= mosi_ch[c][pos];  // set up before the leading edge
            end
            wait_to_sample((b == 0) ? setup_cycles : half);
            if (!mode[0]) begin
                got[pos]    = spi_miso;
                last_sample = cycle + 1;
            end
            @(posedge S_REV);
            spi_sck <= ~mode[1];
            sck_started = 1'b1;
            if (mode[0]) begin
                spi_mosi <= mosi_ch[c][pos];
            end
            wait_to_sample(half);
            if (mode[0]) begin
                got[pos]    = spi_miso;
                last_sample = cycle + 1;
            end
            @(posedge S_REV);
            spi_sck <= mode[1];
            if (j == nb - 1) begin
                assert (got == exp_tx[c]) else begin
                    errors++;
                    $display("Fail %0t: miso char %0d is %h, expected %h",
                             $time, c, got, exp_tx[c]);
                end
                got = '0;
            end
        end

        wait_to_sample(half);
        @(posedge S_REV);
        spi_cs   <= 1'b1;
        spi_mosi <= 1'b0;
        repeat (gap) @(posedge S_REV);
        assert (rx_count == exp_rx) else begin
            errors++;
            $display("Fail %0t: rx_valid pulsed %0d times, expected %0d",
                     $time, rx_count, exp_rx);
        end
        assert (tx_count == (en ? 1 : 0)) else begin
            errors++;
            $display("Fail %0t: tx_load pulsed %0d times in frame %0d", $time, tx_count, frames);
        end
        frames++;
    endtask

    // rx_valid and tx_load low, miso high
    task automatic check_idle();
        assert (spi_miso === 1'b1 && rx_valid === 1'b0 && tx_load === 1'b0) else begin
            errors++;
            $display("Fail %0t: outputs not idle, miso %b rx_valid %b tx_load %b",
                     $time, spi_miso, rx_valid, tx_load);
        end
    endtask

    initial begin
        int         k;
        logic [1:0] mode;
        logic       lsb;
        logic [3:0] len;
        logic       en;
        logic       cut_short;
        S_RESETN  = 1'b0;
        enable    = 1'b0;
        cpol      = 1'b0;
        cpha      = 1'b0;
        lsb_first = 1'b0;
        char_len  = 4'd7;
        tx_word   = '0;
        spi_cs    = 1'b1;
        spi_sck   = 1'b0;
        spi_mosi  = 1'b0;
        repeat (reset_cycles) @(posedge S_REV);
        S_RESETN <= 1'b1;
        @(negedge S_REV);
        check_idle();
        repeat (4) @(posedge S_REV);
        @(negedge S_REV);
        check_idle();

        for (k = 0; k < n_frames; k++) begin
            mode      = 2'(rand_below(4));
            lsb       = 1'(rand_below(2));
            len       = 4'(rand_below(16));
            en        = (rand_below(16) != 0);
            cut_short = (rand_below(16) == 0);
            if (k < 8) begin
                mode      = 2'(k);  // every mode, bytes msb first then words lsb first
                lsb       = (k >= 4);
                len       = (k >= 4) ? 4'd15 : 4'd7;
                en        = 1'b1;
                cut_short = 1'b0;
            end else if (k < 13) begin
                en        = (k != 12);
                cut_short = (k == 10);
                if (k == 8) begin
                    len = 4'd4;
                end else if (k == 9) begin
                    len = 4'd11;
                end
            end
            run_frame(mode, lsb, len, en, cut_short);
        end

        $display("frames %0d, rx words %0d, errors %0d", frames, words, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle < timeout_cycles) @(posedge S_REV);
        $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
        $display("frames %0d, rx words %0d, errors %0d", frames, words, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* design/spi_slave_top.sv */
`timescale 1ns/1ns

module spi_slave_top (
    input  logic                                      S_REV,
    input  logic                                      S_RESETN,
    input  logic                                      enable,
    input  logic                                      cpol,
    input  logic                                      cpha,
    input  logic                                      lsb_first,
    input  logic [spi_slave_pkg::char_len_nbits-1:0]  char_len,
    input  logic [spi_slave_pkg::word_nbits-1:0]      tx_word,
    input  logic                                      spi_cs,
    input  logic                                      spi_sck,
    input  logic                                      spi_mosi,
    output logic                                      spi_miso,
    output logic [spi_slave_pkg::word_nbits-1:0]      rx_word,
    output logic                                      rx_valid,
    output logic                                      tx_load
);
    import spi_slave_pkg::*;

    logic                      cs_active;
    logic                      cs_start;
    logic                      sample_strobe;
    logic                      shift_strobe;
    logic                      mosi_bit;
    logic                      char_load;
    logic                      char_done;
    logic [char_max_nbits-1:0] tx_char;
    logic [char_max_nbits-1:0] rx_char;

    spi_sck_sync u_spi_sck_sync (
        .S_REV         (S_REV),
        .S_RESETN      (S_RESETN),
        .enable        (enable),
        .cpol          (cpol),
        .cpha          (cpha),
        .spi_cs        (spi_cs),
        .spi_sck       (spi_sck),
        .spi_mosi      (spi_mosi),
        .cs_active     (cs_active),
        .cs_start      (cs_start),
        .sample_strobe (sample_strobe),
        .shift_strobe  (shift_strobe),
        .mosi_bit      (mosi_bit)
    );

    spi_char_trx u_spi_char_trx (
        .S_REV         (S_REV),
        .S_RESETN      (S_RESETN),
        .lsb_first     (lsb_first),
        .char_len      (char_len),
        .cs_active     (cs_active),
        .cs_start      (cs_start),
        .sample_strobe (sample_strobe),
        .shift_strobe  (shift_strobe),
        .mosi_bit      (mosi_bit),
        .tx_char       (tx_char),
        .char_load     (char_load),
        .char_done     (char_done),
        .rx_char       (rx_char),
        .spi_miso      (spi_miso)
    );

    spi_word_pack u_spi_word_pack (
        .S_REV     (S_REV),
        .S_RESETN  (S_RESETN),
        .char_len  (char_len),
        .cs_active (cs_active),
        .char_load (char_load),
        .char_done (char_done),
        .rx_char   (rx_char),
        .tx_word   (tx_word),
        .tx_char   (tx_char),
        .tx_load   (tx_load),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid)
    );

endmodule

/* spi_char/spi_word_pack.sv */
`timescale 1ns/1ns

module spi_word_pack (
    input  logic                                      S_REV,
    input  logic                                      S_RESETN,
    input  logic [spi_slave_pkg::char_len_nbits-1:0]  char_len,
    input  logic                                      cs_active,
    input  logic                                      char_load,
    input  logic                                      char_done,
    input  logic [spi_slave_pkg::char_max_nbits-1:0]  rx_char,
    input  logic [spi_slave_pkg::word_nbits-1:0]      tx_word,
    output logic [spi_slave_pkg::char_max_nbits-1:0]  tx_char,
    output logic                                      tx_load,
    output logic [spi_slave_pkg::word_nbits-1:0]      rx_word,
    output logic                                      rx_valid
);
    import spi_slave_pkg::*;

    pack_state_t               state;
    logic [1:0]                slot;
    logic [1:0]                tx_slot;
    logic [1:0]                last_slot;
    logic                      word_done;
    logic                      byte_mode;
    logic                      take_char;
    logic [char_max_nbits-1:0] char_mask;
    logic [char_max_nbits-1:0] tx_slice;
    logic [char_max_nbits-1:0] rx_masked;
    logic [word_nbits-1:0]     tx_hold;
    logic [word_nbits-1:0]     tx_src;
    logic [word_nbits-1:0]     rx_asm;
    logic [word_nbits-1:0]     rx_merged;

    assign byte_mode = (char_len <= byte_mode_max_len);
    assign last_slot = byte_mode ? 2'd3 : 2'd1;
    assign char_mask = ~({char_max_nbits{1'b1}} << ({1'b0, char_len} + 5'd1));

    // one word per selection, extra characters shift out ones
    assign tx_load   = cs_active & char_load & (state == pack_idle) & ~word_done;
    assign tx_src    = tx_load ? tx_word : tx_hold;
    assign tx_slot   = (state == pack_idle) ? 2'd0 : slot + 2'd1;
    assign take_char = cs_active & char_done & (state != pack_idle);
    assign rx_masked = rx_char & char_mask;

    always_comb begin
        if (byte_mode) begin
            tx_slice = {{(char_max_nbits/2){1'b0}},
                        tx_src[{tx_slot, 3'b000} +: char_max_nbits/2]};
        end else begin
            tx_slice = tx_src[{tx_slot[0], 4'b0000} +: char_max_nbits];
        end
        if (tx_load || state == pack_active) begin
            tx_char = tx_slice & char_mask;
        end else begin
            tx_char = '1;
        end
    end

    // slot 0 sits in the low bits
    always_comb begin
        rx_merged = rx_asm;
        if (byte_mode) begin
            rx_merged[{slot, 3'b000} +: char_max_nbits/2] = rx_masked[char_max_nbits/2-1:0];
        end else begin
            rx_merged[{slot[0], 4'b0000} +: char_max_nbits] = rx_masked;
        end
    end

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state     <= pack_idle;
            slot      <= 2'd0;
            word_done <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!cs_active) begin
                state     <= pack_idle;  // partial word dropped
                slot      <= 2'd0;
                word_done <= 1'b0;
            end else begin
                case (state)
                    pack_idle: begin
                        if (tx_load) begin
                            state <= pack_active;
                            slot  <= 2'd0;
                        end
                    end
                    pack_active: begin
                        if (char_done) begin
                            slot <= slot + 2'd1;
                            if (slot + 2'd1 == last_slot) begin
                                state <= pack_last;
                            end
                        end
                    end
                    pack_last: begin
                        if (char_done) begin
                            rx_valid  <= 1'b1;
                            word_done <= 1'b1;
                            state     <= pack_idle;
                            slot      <= 2'd0;
                        end
                    end
                    default: begin
                        state <= pack_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge S_REV) begin
        if (tx_load) begin
            tx_hold <= tx_word;
        end
        if (take_char) begin
            rx_asm <= rx_merged;
        end
        if (take_char && state == pack_last) begin
            rx_word <= rx_merged;
        end
    end

endmodule

/* spi_char/spi_char_trx.sv */
`timescale 1ns/1ns

module spi_char_trx (
    input  logic                                      S_REV,
    input  logic                                      S_RESETN,
    input  logic                                      lsb_first,
    input  logic [spi_slave_pkg::char_len_nbits-1:0]  char_len,
    input  logic                                      cs_active,
    input  logic                                      cs_start,
    input  logic                                      sample_strobe,
    input  logic                                      shift_strobe,
    input  logic                                      mosi_bit,
    input  logic [spi_slave_pkg::char_max_nbits-1:0]  tx_char,
    output logic                                      char_load,
    output logic                                      char_done,
    output logic [spi_slave_pkg::char_max_nbits-1:0]  rx_char,
    output logic                                      spi_miso
);
    import spi_slave_pkg::*;

    trx_state_t                state;
    logic [char_len_nbits-1:0] ptr;
    logic [char_len_nbits-1:0] ptr_first;
    logic [char_len_nbits-1:0] ptr_last;
    logic [char_max_nbits-1:0] tx_shift;
    logic [char_max_nbits-1:0] rx_shift;
    logic [char_max_nbits-1:0] rx_next;
    logic                      take_bit;
    logic                      char_end;

    // msb first walks down from char_len, lsb first walks up from 0
    assign ptr_first = lsb_first ? '0 : char_len;
    assign ptr_last  = lsb_first ? char_len : '0;

    assign take_bit = cs_active & sample_strobe & (state == trx_shift);
    assign char_end = take_bit & (ptr == ptr_last);

    // receive register with the current MOSI bit merged in
    always_comb begin
        rx_next      = rx_shift;
        rx_next[ptr] = mosi_bit;
    end

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state     <= trx_idle;
            ptr       <= '0;
            char_load <= 1'b0;
            char_done <= 1'b0;
            spi_miso  <= 1'b1;
        end else begin
            char_load <= 1'b0;
            char_done <= 1'b0;
            if (!cs_active) begin
                state    <= trx_idle;
                ptr      <= ptr_first;
                spi_miso <= 1'b1;  // idle level while deselected
            end else begin
                case (state)
                    trx_idle: begin
                        if (cs_start) begin
                            char_load <= 1'b1;
                        end
                        // first character arrives one cycle after the request
                        if (char_load) begin
                            state    <= trx_shift;
                            ptr      <= ptr_first;
                            spi_miso <= tx_char[ptr_first];
                        end
                    end
                    trx_shift: begin
                        if (char_end) begin
                            char_done <= 1'b1;
                            char_load <= 1'b1;  // ask for the next one
                            ptr       <= ptr_first;
                        end else if (take_bit) begin
                            ptr <= lsb_first ? ptr + 1'b1 : ptr - 1'b1;
                        end
                        if (shift_strobe) begin
                            spi_miso <= tx_shift[ptr];
                        end
                    end
                    default: begin
                        state <= trx_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge S_REV) begin
        if (char_load) begin
            tx_shift <= tx_char;
        end
        if (take_bit) begin
            rx_shift <= rx_next;
        end
        if (char_end) begin
            rx_char <= rx_next;  // includes the last bit
        end
    end

endmodule

/* design/spi_sck_sync.sv */
`timescale 1ns/1ns

module spi_sck_sync (
    input  logic S_REV,
    input  logic S_RESETN,
    input  logic enable,
    input  logic cpol,
    input  logic cpha,
    input  logic spi_cs,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic cs_active,
    output logic cs_start,
    output logic sample_strobe,
    output logic shift_strobe,
    output logic mosi_bit
);
    import spi_slave_pkg::*;

    logic [sync_stages-1:0] sck_q;
    logic [sync_stages-1:0] cs_q;
    logic [sync_stages-1:0] mosi_q;
    logic                   sck_prev;
    logic                   cs_prev;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   selected;
    logic                   sample_edge;
    logic                   shift_edge;
    spi_mode_t              mode;

    assign mode     = spi_mode_t'({cpol, cpha});
    assign sck_rise = sck_q[sync_stages-1] & ~sck_prev;
    assign sck_fall = ~sck_q[sync_stages-1] & sck_prev;
    assign selected = enable & ~cs_q[sync_stages-1];
    assign mosi_bit = mosi_q[sync_stages-1];

    // leading edge samples when cpha is 0, trailing edge when cpha is 1
    always_comb begin
        case (mode)
            mode_0, mode_3: begin
                sample_edge = sck_rise;
                shift_edge  = sck_fall;
            end
            default: begin
                sample_edge = sck_fall;
                shift_edge  = sck_rise;
            end
        endcase
    end

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            sck_q         <= '0;
            cs_q          <= '1;  // deselected
            mosi_q        <= '0;
            sck_prev      <= 1'b0;
            cs_prev       <= 1'b1;
            cs_active     <= 1'b0;
            cs_start      <= 1'b0;
            sample_strobe <= 1'b0;
            shift_strobe  <= 1'b0;
        end else begin
            sck_q         <= {sck_q[sync_stages-2:0], spi_sck};
            cs_q          <= {cs_q[sync_stages-2:0], spi_cs};
            mosi_q        <= {mosi_q[sync_stages-2:0], spi_mosi};
            sck_prev      <= sck_q[sync_stages-1];
            cs_prev       <= cs_q[sync_stages-1];
            cs_active     <= selected;
            cs_start      <= selected & cs_prev;  // cs falling edge
            sample_strobe <= selected & sample_edge;
            shift_strobe  <= selected & shift_edge;
        end
    end

endmodule

/* common/spi_slave_pkg.sv */
package spi_slave_pkg;

    // word and character sizes
    localparam int word_nbits     = 32;
    localparam int char_max_nbits = 16;
    localparam int char_len_nbits = 4;   // char_len holds width minus one

    // input synchronizer depth
    localparam int sync_stages = 2;

    // char_len up to this value packs 8-bit slots, above it 16-bit slots
    localparam int byte_mode_max_len = 7;

    // SPI mode number, built as {cpol, cpha}
    typedef enum logic [1:0] {
        mode_0 = 2'b00,  // idle low, sample on rising
        mode_1 = 2'b01,  // idle low, sample on falling
        mode_2 = 2'b10,  // idle high, sample on falling
        mode_3 = 2'b11   // idle high, sample on rising
    } spi_mode_t;

    // character transceiver
    typedef enum logic {
        trx_idle  = 1'b0,  // waiting for selection
        trx_shift = 1'b1   // bits moving
    } trx_state_t;

    // word packer
    typedef enum logic [1:0] {
        pack_idle   = 2'b00,  // no word in flight
        pack_active = 2'b01,  // slots before the last one
        pack_last   = 2'b10   // last slot in flight
    } pack_state_t;

endpackage
